// ==== all.f ====
+incdir+source
source/scratchpad_pkg.sv
source/scratchpad_ifs.sv
source/instr_fifo.sv
source/load_fsm.sv
source/gemm_fsm.sv
source/scratchpad_bank.sv
source/scratchpad.sv
sim/scratchpad_checker.sv
sim/scratchpad_assertions.sv
sim/scratchpad_tb.sv

// ==== Bender.yml ====
package:
  name: scratchpad

sources:
  - include_dirs:
      - source
    files:
      - source/scratchpad_pkg.sv
      - source/scratchpad_ifs.sv
      - source/instr_fifo.sv
      - source/load_fsm.sv
      - source/gemm_fsm.sv
      - source/scratchpad_bank.sv
      - source/scratchpad.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/scratchpad_checker.sv
      - sim/scratchpad_assertions.sv
      - sim/scratchpad_tb.sv

// ==== sim/scratchpad_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_defs.svh"

module scratchpad_tb import scratchpad_pkg::*; ();

    localparam int N_INSTR = 12;
    localparam int WAIT_LIMIT = 3000;
    localparam int IDLE_CYCLES = 6;

    logic CLK;
    logic rst = 1'b1;
    logic instr_wen = 1'b0;
    instr_t instr_wdata = '0;
    logic instr_full;
    logic sLoad;
    addr_t load_addr;
    logic sLoad_hit = 1'b0;
    row_sel_t sLoad_row = '0;
    row_t load_data = '0;
    logic weight_enable;
    logic input_enable;
    logic partial_enable;
    row_t weight_input_data;
    row_sel_t weight_input_row_sel;
    row_t partial_sum_data;
    row_sel_t partial_sum_row_sel;
    logic gemm_complete;
    logic fifo_has_space = 1'b0;
    logic drained = 1'b0;

    int seed = 40379;
    int tb_errors = 0;
    int chk_errors;
    int chk_pending;
    bit timed_out = 1'b0;
    bit full_seen = 1'b0;
    bit gemm_active = 1'b0;
    bit overlap_seen = 1'b0;

    // Memory and array model state
    logic models_on = 1'b0;
    int mem_delay = 0;
    int drain_wait = 0;
    int rows_seen = 0;
    row_sel_t mem_row = '0;

    instr_t instr_table [N_INSTR];
    row_t slot_img [`SP_SLOTS][`SP_ROWS];

    scratchpad scratchpad_i (.*);

    scratchpad_checker checker_i (
        .CLK(CLK),
        .rst(rst),
        .weight_enable(weight_enable),
        .input_enable(input_enable),
        .partial_enable(partial_enable),
        .weight_input_data(weight_input_data),
        .weight_input_row_sel(weight_input_row_sel),
        .partial_sum_data(partial_sum_data),
        .partial_sum_row_sel(partial_sum_row_sel),
        .gemm_complete(gemm_complete),
        .drained(drained),
        .errors(chk_errors),
        .outstanding(chk_pending)
    );

    bind scratchpad scratchpad_assertions scratchpad_assertions_i (
        .CLK(CLK),
        .rst(rst),
        .sLoad(sLoad),
        .sLoad_hit(sLoad_hit),
        .load_addr(load_addr),
        .fifo_has_space(fifo_has_space),
        .input_enable(input_enable),
        .partial_enable(partial_enable),
        .gemm_complete(gemm_complete)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Every DRAM element depends on the whole address and its index
    function automatic row_t row_at(input addr_t addr);
        row_t r;
        int e;
        for (e = 0; e < 4; e++) begin
            r[e*16 +: 16] = (addr[15:0] + 16'(e) * 16'h0123) ^ addr[31:16] ^ 16'hc3a5;
        end
        return r;
    endfunction

    function automatic instr_t load_instr(input slot_t slot, input addr_t base);
        return {`SP_OP_LOAD, slot, base};
    endfunction

    function automatic instr_t gemm_instr(input logic nw, input slot_t w, input slot_t i,
                                          input slot_t p);
        return {`SP_OP_GEMM, 4'h0, 19'h0, nw, w, i, p};
    endfunction

    task automatic build_table();
        instr_table[0] = load_instr(4'd0, 32'h0000_1000);
        instr_table[1] = load_instr(4'd1, 32'h0002_2040);
        instr_table[2] = load_instr(4'd2, 32'h0013_30a0);
        instr_table[3] = gemm_instr(1'b1, 4'd0, 4'd1, 4'd2);
        // Loads into free slots overlap the GEMM above
        instr_table[4] = load_instr(4'd3, 32'h00a0_4100);
        instr_table[5] = load_instr(4'd4, 32'h1234_5000);
        instr_table[6] = gemm_instr(1'b0, 4'd0, 4'd3, 4'd4);
        instr_table[7] = gemm_instr(1'b1, 4'd3, 4'd4, 4'd1);
        instr_table[8] = load_instr(4'd5, 32'h0000_6200);
        instr_table[9] = gemm_instr(1'b0, 4'd0, 4'd5, 4'd0);
        // Unknown opcode that the decoder drops
        instr_table[10] = {2'b00, 4'd7, 32'h0000_0000};
        instr_table[11] = gemm_instr(1'b1, 4'd2, 4'd2, 4'd5);
    endtask

    // Walk the table in order and queue the expected array events
    task automatic build_expected();
        int k;
        int r;
        logic [1:0] op;
        slot_t slot;
        addr_t base;
        for (k = 0; k < N_INSTR; k++) begin
            {op, slot, base} = instr_table[k];
            if (op == `SP_OP_LOAD) begin
                for (r = 0; r < `SP_ROWS; r++) begin
                    slot_img[slot][r] = row_at(base + addr_t'(r * `SP_ROW_BYTES));
                end
            end else if (op == `SP_OP_GEMM) begin
                if (base[12]) begin
                    for (r = 0; r < `SP_ROWS; r++) begin
                        checker_i.add_weight(row_sel_t'(r), slot_img[base[11:8]][r]);
                    end
                end
                for (r = 0; r < `SP_ROWS; r++) begin
                    checker_i.add_input(row_sel_t'(r), slot_img[base[7:4]][r],
                        slot_img[base[3:0]][r]);
                end
                checker_i.add_done();
            end
        end
    endtask

    task automatic check_idle();
        repeat (IDLE_CYCLES) begin
            @(negedge CLK);
            if (sLoad || weight_enable || input_enable || partial_enable || gemm_complete
                    || instr_full) begin
                $display("** Error at time %0t: output active before any instruction", $time);
                tb_errors++;
            end
        end
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (instr_full && !timed_out) begin
            full_seen = 1'b1;
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timeout: instruction FIFO stayed full for %0d cycles", WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic push_instr(input instr_t ins);
        instr_wen = 1'b1;
        instr_wdata = ins;
        @(negedge CLK);
        instr_wen = 1'b0;
    endtask

    task automatic wait_stream_done();
        int n;
        n = 0;
        while (chk_pending != 0 && !timed_out) begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timeout: %0d expected array events never arrived", chk_pending);
                timed_out = 1'b1;
            end
        end
    endtask

    always @(posedge CLK) begin
        models_on <= !rst;
    end

    // A load request while rows of an earlier GEMM are still streaming
    always @(posedge CLK) begin
        if (rst || gemm_complete) begin
            gemm_active <= 1'b0;
        end else if (weight_enable || input_enable) begin
            gemm_active <= 1'b1;
        end
        if (sLoad && gemm_active) begin
            overlap_seen <= 1'b1;
        end
    end

    // Memory and systolic array models share one process and one seed
    always @(negedge CLK) begin
        if (!models_on) begin
            sLoad_hit = 1'b0;
            fifo_has_space = 1'b0;
            drained = 1'b0;
            mem_row = '0;
            mem_delay = 0;
            drain_wait = 0;
            rows_seen = 0;
        end else begin
            if (sLoad_hit) begin
                sLoad_hit = 1'b0;
            end else if (sLoad) begin
                if (mem_delay == 0) begin
                    sLoad_hit = 1'b1;
                    load_data = row_at(load_addr);
                    sLoad_row = mem_row;
                    mem_row = mem_row + 1'b1;
                    mem_delay = $random(seed) & 3;
                end else begin
                    mem_delay--;
                end
            end
            fifo_has_space = ($random(seed) & 3) != 0;
            // A single cycle of drained ends the DRAIN state
            if (drained) begin
                drained = 1'b0;
            end else if (drain_wait != 0) begin
                drain_wait--;
                if (drain_wait == 0) begin
                    drained = 1'b1;
                end
            end
            if (input_enable) begin
                rows_seen++;
                if (rows_seen == `SP_ROWS) begin
                    rows_seen = 0;
                    drain_wait = 1 + ($random(seed) & 3);
                end
            end
        end
    end

    initial begin
        int k;
        int assert_fails;
        build_table();
        build_expected();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        check_idle();
        for (k = 0; k < N_INSTR && !timed_out; k++) begin
            wait_not_full();
            if (!timed_out) begin
                push_instr(instr_table[k]);
            end
        end
        wait_stream_done();
        // Quiet tail catches stray rows or completions
        repeat (20) @(negedge CLK);
        if (!full_seen && !timed_out) begin
            $display("Instruction FIFO never filled during the burst");
            tb_errors++;
        end
        if (!overlap_seen && !timed_out) begin
            $display("No load ran while an earlier GEMM was still streaming");
            tb_errors++;
        end
        assert_fails = scratchpad_i.scratchpad_assertions_i.fail_count;
        $display("Checks done: %0d array mismatches, %0d testbench errors, %0d assertion failures",
            chk_errors, tb_errors, assert_fails);
        if (chk_errors == 0 && tb_errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/scratchpad_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratchpad_assertions import scratchpad_pkg::*; (
    input wire logic CLK,
    input wire logic rst,
    input wire logic sLoad,
    input wire logic sLoad_hit,
    input wire addr_t load_addr,
    input wire logic fifo_has_space,
    input wire logic input_enable,
    input wire logic partial_enable,
    input wire logic gemm_complete
);

    int fail_count = 0;

    // Request holds its address until the memory answers
    load_addr_held: assert property (@(posedge CLK) disable iff (rst)
        (sLoad && !sLoad_hit) |=> (sLoad && $stable(load_addr)))
    else begin
        $error("load_addr moved or sLoad dropped before the hit");
        fail_count++;
    end

    // Row output only for a read issued with space in the array FIFO
    input_paced: assert property (@(posedge CLK) disable iff (rst)
        (input_enable || partial_enable) |-> $past(fifo_has_space))
    else begin
        $error("input row emitted for a read issued without fifo_has_space");
        fail_count++;
    end

    complete_pulse: assert property (@(posedge CLK) disable iff (rst)
        gemm_complete |=> !gemm_complete)
    else begin
        $error("gemm_complete held longer than one cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== sim/scratchpad_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratchpad_checker import scratchpad_pkg::*; (
    input wire logic CLK,
    input wire logic rst,
    input wire logic weight_enable,
    input wire logic input_enable,
    input wire logic partial_enable,
    input wire row_t weight_input_data,
    input wire row_sel_t weight_input_row_sel,
    input wire row_t partial_sum_data,
    input wire row_sel_t partial_sum_row_sel,
    input wire logic gemm_complete,
    input wire logic drained,
    output int errors,
    output int outstanding
);

    localparam logic [1:0] KIND_WEIGHT = 2'd0;
    localparam logic [1:0] KIND_INPUT = 2'd1;
    localparam logic [1:0] KIND_DONE = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        row_sel_t row;
        row_t a;
        row_t b;
    } exp_t;

    // Expected array events in the order they must appear
    exp_t exp_q [$];
    int err_cnt = 0;
    int pend_cnt = 0;
    logic prev_weight = 1'b0;

    assign errors = err_cnt;
    assign outstanding = pend_cnt;

    task automatic add_weight(input row_sel_t row, input row_t data);
        exp_q.push_back({KIND_WEIGHT, row, data, row_t'(0)});
        pend_cnt = exp_q.size();
    endtask

    task automatic add_input(input row_sel_t row, input row_t in_data, input row_t ps_data);
        exp_q.push_back({KIND_INPUT, row, in_data, ps_data});
        pend_cnt = exp_q.size();
    endtask

    task automatic add_done();
        exp_q.push_back({KIND_DONE, row_sel_t'(0), row_t'(0), row_t'(0)});
        pend_cnt = exp_q.size();
    endtask

    task automatic flag(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic take(input logic [1:0] kind, input string what,
                        output exp_t ev, output bit ok);
        ok = 1'b0;
        ev = '0;
        if (exp_q.size() == 0) begin
            flag({"unexpected ", what});
        end else begin
            ev = exp_q.pop_front();
            pend_cnt = exp_q.size();
            if (ev.kind != kind) begin
                flag($sformatf("%s out of order, expected event kind %0d", what, ev.kind));
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // Outputs are sampled at the rising edge like a downstream register
    always @(posedge CLK) begin
        exp_t ev;
        bit ok;
        if (!rst) begin
            if (input_enable !== partial_enable) begin
                flag("input_enable and partial_enable differ");
            end
            if (weight_enable) begin
                if (weight_input_row_sel != '0 && !prev_weight) begin
                    flag("weight rows not on consecutive cycles");
                end
                take(KIND_WEIGHT, "weight row", ev, ok);
                if (ok && (weight_input_row_sel !== ev.row || weight_input_data !== ev.a)) begin
                    flag($sformatf("weight row %0d: got sel %0d data %h, expected %h",
                        ev.row, weight_input_row_sel, weight_input_data, ev.a));
                end
            end
            if (input_enable) begin
                take(KIND_INPUT, "input row", ev, ok);
                if (ok && (weight_input_row_sel !== ev.row || partial_sum_row_sel !== ev.row
                        || weight_input_data !== ev.a || partial_sum_data !== ev.b)) begin
                    flag($sformatf("input row %0d: got sel %0d/%0d data %h/%h, expected %h/%h",
                        ev.row, weight_input_row_sel, partial_sum_row_sel,
                        weight_input_data, partial_sum_data, ev.a, ev.b));
                end
            end
            if (gemm_complete) begin
                if (!drained) begin
                    flag("gemm_complete while drained is low");
                end
                take(KIND_DONE, "gemm_complete", ev, ok);
            end
        end
        prev_weight = !rst && weight_enable;
    end

endmodule

`default_nettype wire

// ==== source/scratchpad.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_defs.svh"

module scratchpad import scratchpad_pkg::*; (
    input wire logic CLK,
    input wire logic rst,

    // Host instruction push
    input wire logic instr_wen,
    input wire instr_t instr_wdata,
    output logic instr_full,

    // DRAM load port
    output logic sLoad,
    output addr_t load_addr,
    input wire logic sLoad_hit,
    input wire row_sel_t sLoad_row,
    input wire row_t load_data,

    // Systolic array
    output logic weight_enable,
    output logic input_enable,
    output logic partial_enable,
    output row_t weight_input_data,
    output row_sel_t weight_input_row_sel,
    output row_t partial_sum_data,
    output row_sel_t partial_sum_row_sel,
    output logic gemm_complete,
    input wire logic fifo_has_space,
    input wire logic drained
);

    instr_t instr_rdata;
    logic instr_empty;
    logic instr_ren;

    load_bank_if lb_if ();
    gemm_bank_if gb_if ();
    gemm_cmd_if cmd_if ();

    instr_fifo #(
        .T(instr_t),
        .DEPTH(`SP_INSTR_DEPTH)
    ) instr_fifo_i (
        .CLK(CLK),
        .rst(rst),
        .wen(instr_wen),
        .wdata(instr_wdata),
        .ren(instr_ren),
        .rdata(instr_rdata),
        .full(instr_full),
        .empty(instr_empty)
    );

    load_fsm load_fsm_i (
        .CLK(CLK),
        .rst(rst),
        .instr(instr_rdata),
        .instr_empty(instr_empty),
        .instr_ren(instr_ren),
        .sLoad(sLoad),
        .load_addr(load_addr),
        .sLoad_hit(sLoad_hit),
        .sLoad_row(sLoad_row),
        .load_data(load_data),
        .bank(lb_if.master),
        .cmd(cmd_if.dispatch)
    );

    gemm_fsm gemm_fsm_i (
        .CLK(CLK),
        .rst(rst),
        .cmd(cmd_if.engine),
        .bank(gb_if.reader),
        .fifo_has_space(fifo_has_space),
        .drained(drained),
        .weight_enable(weight_enable),
        .input_enable(input_enable),
        .partial_enable(partial_enable),
        .weight_input_data(weight_input_data),
        .weight_input_row_sel(weight_input_row_sel),
        .partial_sum_data(partial_sum_data),
        .partial_sum_row_sel(partial_sum_row_sel),
        .gemm_complete(gemm_complete)
    );

    // Single bank shared by loads and GEMM reads
    scratchpad_bank scratchpad_bank_i (
        .CLK(CLK),
        .wr(lb_if.store),
        .rd(gb_if.store)
    );

endmodule

`default_nettype wire

// ==== source/scratchpad_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_defs.svh"

module scratchpad_bank import scratchpad_pkg::*; (
    input wire logic CLK,
    load_bank_if.store wr,
    gemm_bank_if.store rd
);

    localparam int DEPTH = `SP_SLOTS * `SP_ROWS;
    localparam int ADDR_W = $bits(slot_t) + $bits(row_sel_t);

    // Rows of one slot are contiguous
    row_t mem [DEPTH];

    logic [ADDR_W-1:0] waddr;
    logic [ADDR_W-1:0] raddr_a;
    logic [ADDR_W-1:0] raddr_b;

    assign waddr = {wr.wslot, wr.wrow};
    assign raddr_a = {rd.rslot_a, rd.rrow};
    assign raddr_b = {rd.rslot_b, rd.rrow};

    always_ff @(posedge CLK) begin
        if (wr.wen) begin
            mem[waddr] <= wr.wdata;
        end
    end

    // Both ports share the row index, one cycle of latency
    always_ff @(posedge CLK) begin
        if (rd.ren) begin
            rd.rdata_a <= mem[raddr_a];
            rd.rdata_b <= mem[raddr_b];
        end
    end

endmodule

`default_nettype wire

// ==== source/gemm_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_defs.svh"

module gemm_fsm import scratchpad_pkg::*; (
    input wire logic CLK,
    input wire logic rst,
    gemm_cmd_if.engine cmd,
    gemm_bank_if.reader bank,
    input wire logic fifo_has_space,
    input wire logic drained,
    output logic weight_enable,
    output logic input_enable,
    output logic partial_enable,
    output row_t weight_input_data,
    output row_sel_t weight_input_row_sel,
    output row_t partial_sum_data,
    output row_sel_t partial_sum_row_sel,
    output logic gemm_complete
);

    localparam row_sel_t LAST_ROW = row_sel_t'(`SP_ROWS - 1);

    gemm_state_t state_q;
    row_sel_t row_q;
    slot_t w_slot_q;
    slot_t i_slot_q;
    slot_t p_slot_q;

    // Tracks the read whose data shows up this cycle
    logic w_pend_q;
    logic in_pend_q;
    row_sel_t pend_row_q;

    logic rd_weight;
    logic rd_input;
    logic done;
    logic launch;

    assign rd_weight = (state_q == WEIGHT);
    assign rd_input = (state_q == INPUT) && fifo_has_space;

    // Last input row must be out before completion
    assign done = (state_q == DRAIN) && drained && !in_pend_q;
    assign launch = cmd.start && ((state_q == IDLE) || done);

    assign gemm_complete = done;
    assign cmd.busy = (state_q != IDLE) && !done;

    assign bank.ren = rd_weight || rd_input;
    assign bank.rslot_a = rd_weight ? w_slot_q : i_slot_q;
    assign bank.rslot_b = p_slot_q;
    assign bank.rrow = row_q;

    // Bank output registers feed the array directly
    assign weight_enable = w_pend_q;
    assign input_enable = in_pend_q;
    assign partial_enable = in_pend_q;
    assign weight_input_data = bank.rdata_a;
    assign partial_sum_data = bank.rdata_b;
    assign weight_input_row_sel = pend_row_q;
    assign partial_sum_row_sel = pend_row_q;

    always_ff @(posedge CLK) begin
        if (launch) begin
            w_slot_q <= cmd.weight_slot;
            i_slot_q <= cmd.input_slot;
            p_slot_q <= cmd.psum_slot;
        end
        if (bank.ren) begin
            pend_row_q <= row_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q <= IDLE;
            row_q <= '0;
            w_pend_q <= 1'b0;
            in_pend_q <= 1'b0;
        end else begin
            w_pend_q <= rd_weight;
            in_pend_q <= rd_input;
            if (launch) begin
                // Weights are skipped when the array keeps its old ones
                row_q <= '0;
                state_q <= cmd.new_weight ? WEIGHT : INPUT;
            end else begin
                case (state_q)
                    WEIGHT: begin
                        row_q <= row_q + 1'b1;
                        if (row_q == LAST_ROW) begin
                            state_q <= INPUT;
                        end
                    end
                    INPUT: begin
                        if (fifo_has_space) begin
                            row_q <= row_q + 1'b1;
                            if (row_q == LAST_ROW) begin
                                state_q <= DRAIN;
                            end
                        end
                    end
                    DRAIN: begin
                        if (done) begin
                            state_q <= IDLE;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/load_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_defs.svh"

module load_fsm import scratchpad_pkg::*; (
    input wire logic CLK,
    input wire logic rst,
    input wire instr_t instr,
    input wire logic instr_empty,
    output logic instr_ren,
    output logic sLoad,
    output addr_t load_addr,
    input wire logic sLoad_hit,
    input wire row_sel_t sLoad_row,
    input wire row_t load_data,
    load_bank_if.master bank,
    gemm_cmd_if.dispatch cmd
);

    localparam row_sel_t LAST_ROW = row_sel_t'(`SP_ROWS - 1);

    load_state_t state_q;
    instr_t cur_q;
    row_sel_t row_q;

    opcode_t op;
    slot_t slot;
    addr_t base;

    assign {op, slot, base} = cur_q;

    // Pop whenever an instruction waits in FETCH
    assign instr_ren = (state_q == FETCH) && !instr_empty;

    // Request stays up with a fixed address until the hit
    assign sLoad = (state_q == REQ);
    assign load_addr = base + addr_t'(row_q) * addr_t'(`SP_ROW_BYTES);

    // Returned row goes straight into the store
    assign bank.wen = (state_q == REQ) && sLoad_hit;
    assign bank.wslot = slot;
    assign bank.wrow = sLoad_row;
    assign bank.wdata = load_data;

    // GEMM fields live in the low address bits
    assign cmd.new_weight = base[12];
    assign cmd.weight_slot = base[11:8];
    assign cmd.input_slot = base[7:4];
    assign cmd.psum_slot = base[3:0];
    assign cmd.start = (state_q == WAIT_GEMM) && !cmd.busy;

    always_ff @(posedge CLK) begin
        if (instr_ren) begin
            cur_q <= instr;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q <= FETCH;
            row_q <= '0;
        end else begin
            case (state_q)
                FETCH: begin
                    if (instr_ren) begin
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    row_q <= '0;
                    case (op)
                        `SP_OP_LOAD: state_q <= REQ;
                        `SP_OP_GEMM: state_q <= WAIT_GEMM;
                        // Anything else is dropped
                        default: state_q <= FETCH;
                    endcase
                end
                REQ: begin
                    if (sLoad_hit) begin
                        row_q <= row_q + 1'b1;
                        if (row_q == LAST_ROW) begin
                            state_q <= FETCH;
                        end
                    end
                end
                WAIT_GEMM: begin
                    // start pulses in this cycle and the next instruction may overlap
                    if (!cmd.busy) begin
                        state_q <= FETCH;
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/instr_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4
) (
    input wire logic CLK,
    input wire logic rst,
    input wire logic wen,
    input wire T wdata,
    input wire logic ren,
    output T rdata,
    output logic full,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign push = wen && !full;
    assign pop = ren && !empty;

    // Head is visible without a read cycle
    assign rdata = mem[rptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            // Explicit wrap keeps non-binary depths correct too
            if (push) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (pop) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== source/scratchpad_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Load controller write port into the matrix store
interface load_bank_if import scratchpad_pkg::*; ();
    logic wen;
    slot_t wslot;
    row_sel_t wrow;
    row_t wdata;

    modport master (output wen, wslot, wrow, wdata);
    modport store (input wen, wslot, wrow, wdata);
endinterface

// GEMM controller dual read port, data one cycle after ren
interface gemm_bank_if import scratchpad_pkg::*; ();
    logic ren;
    slot_t rslot_a;
    slot_t rslot_b;
    row_sel_t rrow;
    row_t rdata_a;
    row_t rdata_b;

    modport reader (output ren, rslot_a, rslot_b, rrow, input rdata_a, rdata_b);
    modport store (input ren, rslot_a, rslot_b, rrow, output rdata_a, rdata_b);
endinterface

// GEMM dispatch from the load controller to the GEMM controller
interface gemm_cmd_if import scratchpad_pkg::*; ();
    logic start;
    logic new_weight;
    slot_t weight_slot;
    slot_t input_slot;
    slot_t psum_slot;
    logic busy;

    modport dispatch (
        output start, new_weight, weight_slot, input_slot, psum_slot,
        input busy
    );
    modport engine (
        input start, new_weight, weight_slot, input_slot, psum_slot,
        output busy
    );
endinterface

`default_nettype wire

// ==== source/scratchpad_pkg.sv ====
`default_nettype none

`include "scratchpad_defs.svh"

package scratchpad_pkg;

    // Basic vectors
    typedef logic [`SP_WORD_W-1:0] addr_t;
    typedef logic [`SP_ROW_W-1:0] row_t;
    typedef logic [$clog2(`SP_ROWS)-1:0] row_sel_t;
    typedef logic [$clog2(`SP_SLOTS)-1:0] slot_t;

    // Instruction fields
    typedef logic [1:0] opcode_t;

    // {opcode, slot, address}
    // GEMM packs new_weight and three slots in the address field
    typedef logic [$bits(opcode_t)+$bits(slot_t)+`SP_WORD_W-1:0] instr_t;

    // Load controller
    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        REQ,
        WAIT_GEMM
    } load_state_t;

    // GEMM controller
    typedef enum logic [1:0] {
        IDLE,
        WEIGHT,
        INPUT,
        DRAIN
    } gemm_state_t;

endpackage

`default_nettype wire

// ==== source/scratchpad_defs.svh ====
`ifndef SCRATCHPAD_DEFS_SVH
`define SCRATCHPAD_DEFS_SVH

// DRAM address width
`define SP_WORD_W 32

// One matrix row, four 16-bit elements
`define SP_ROW_W 64

// Matrix geometry and store size
`define SP_ROWS 4
`define SP_SLOTS 16

// Instruction FIFO depth
`define SP_INSTR_DEPTH 4

// Opcodes in the top two instruction bits
`define SP_OP_LOAD 2'b01
`define SP_OP_GEMM 2'b11

// Byte stride between consecutive rows in DRAM
`define SP_ROW_BYTES 8

`endif
